// ==== logic/opc_pkg.sv ====
// operand collector definitions
`default_nettype none

package opc_pkg;

    localparam int num_threads = 4;
    localparam int xlen        = 32;
    localparam int num_regs    = 32;
    localparam int num_warps   = 4;
    localparam int num_banks   = 4;
    localparam int num_srcs    = 3;
    localparam int bank_depth  = 32;

    localparam int reg_bits  = $clog2(num_regs);
    localparam int bank_bits = $clog2(num_banks);

    typedef logic [reg_bits-1:0]             reg_num_t;
    typedef logic [$clog2(num_warps)-1:0]    warp_id_t;
    typedef logic [num_threads-1:0]          tmask_t;
    typedef logic [num_threads*xlen-1:0]     lane_vec_t;
    typedef logic [bank_bits-1:0]            bank_sel_t;
    typedef logic [$clog2(bank_depth)-1:0]   bank_addr_t;
    typedef logic [$clog2(num_srcs)-1:0]     src_idx_t;
    typedef logic [num_srcs-1:0]             src_mask_t;
    typedef logic [7:0]                      tag_t;

    typedef enum logic [1:0] {
        idle,
        read,
        drain
    } ctrl_state_t;

    typedef struct packed {
        warp_id_t warp;
        tmask_t   tmask;
        reg_num_t rd;
        reg_num_t rs1;
        reg_num_t rs2;
        reg_num_t rs3;
        tag_t     tag;
    } issue_req_t;

    typedef struct packed {
        warp_id_t  warp;
        tmask_t    tmask;
        reg_num_t  rd;
        lane_vec_t data;
    } wb_req_t;

    typedef struct packed {
        tag_t      tag;
        warp_id_t  warp;
        tmask_t    tmask;
        reg_num_t  rd;
        lane_vec_t rs1_data;
        lane_vec_t rs2_data;
        lane_vec_t rs3_data;
    } operands_t;

    typedef struct packed {
        logic       valid;
        bank_addr_t addr;
        src_idx_t   src;
    } bank_rd_t;

endpackage

`default_nettype wire

// ==== logic/gpr_bank.sv ====
// register file bank
`timescale 1ns/1ps
`default_nettype none

module gpr_bank (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      wr_en,
    input  wire opc_pkg::bank_addr_t wr_addr,
    input  wire opc_pkg::tmask_t     wr_mask,
    input  wire opc_pkg::lane_vec_t  wr_data,
    input  wire                      rd_en,
    input  wire opc_pkg::bank_addr_t rd_addr,
    output opc_pkg::lane_vec_t       rd_data
);

    opc_pkg::lane_vec_t mem [opc_pkg::bank_depth];

    // reads sample the array before this edge's write lands, so a
    // same-entry collision returns the old value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < opc_pkg::bank_depth; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                for (int l = 0; l < opc_pkg::num_threads; l++) begin
                    if (wr_mask[l]) begin
                        mem[wr_addr][l*opc_pkg::xlen +: opc_pkg::xlen] <=
                            wr_data[l*opc_pkg::xlen +: opc_pkg::xlen];
                    end
                end
            end
            if (rd_en) begin
                rd_data <= mem[rd_addr];
            end
        end
    end

    rd_addr_known: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> !$isunknown(rd_addr));

endmodule

`default_nettype wire

// ==== logic/bank_arbiter.sv ====
// bank conflict arbiter
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
    input  wire opc_pkg::issue_req_t                       issue_req,
    input  wire opc_pkg::src_mask_t                        pending,
    output opc_pkg::bank_rd_t [opc_pkg::num_banks-1:0]     bank_rd,
    output opc_pkg::src_mask_t                             grant
);

    opc_pkg::reg_num_t [opc_pkg::num_srcs-1:0] src_reg;

    // slot 0 is rs1, so the lowest slot also has the highest priority
    assign src_reg = {issue_req.rs3, issue_req.rs2, issue_req.rs1};

    always_comb begin
        bank_rd = '0;
        grant   = '0;
        for (int b = 0; b < opc_pkg::num_banks; b++) begin
            for (int s = 0; s < opc_pkg::num_srcs; s++) begin
                // first pending source that maps here wins the bank
                if (pending[s] && !bank_rd[b].valid
                    && (src_reg[s][opc_pkg::bank_bits-1:0] == opc_pkg::bank_sel_t'(b))) begin
                    bank_rd[b].valid = 1'b1;
                    bank_rd[b].addr  = {issue_req.warp,
                                        src_reg[s][opc_pkg::reg_bits-1:opc_pkg::bank_bits]};
                    bank_rd[b].src   = opc_pkg::src_idx_t'(s);
                    grant[s]         = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/collect_ctrl.sv ====
// operand collector control
`timescale 1ns/1ps
`default_nettype none

module collect_ctrl (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      issue_valid,
    input  wire opc_pkg::issue_req_t issue_req,
    output logic                     issue_ready,
    output opc_pkg::src_mask_t       pending,
    input  wire opc_pkg::src_mask_t  grant,
    output logic                     rd_en,
    output logic                     load_out,
    output logic                     out_valid,
    input  wire                      out_ready
);

    opc_pkg::ctrl_state_t state;
    opc_pkg::ctrl_state_t state_next;
    opc_pkg::src_mask_t   src_valid;
    opc_pkg::src_mask_t   fetched;
    opc_pkg::src_mask_t   fetched_next;
    logic                 out_full;
    logic                 stall;

    // register 0 is hardwired to zero and never needs a bank read
    assign src_valid = {issue_req.rs3 != '0, issue_req.rs2 != '0, issue_req.rs1 != '0};
    assign pending   = src_valid & ~fetched;

    // a held result blocks new reads until the consumer takes it
    assign stall = out_valid && !out_ready;
    assign rd_en = issue_valid && !stall;

    // accept once every remaining source gets its bank in this cycle
    assign issue_ready = rd_en && ((pending & ~grant) == '0);

    // drain is the cycle where the last read returns and the output loads
    assign load_out  = (state == opc_pkg::drain);
    assign out_valid = load_out || out_full;

    always_comb begin
        fetched_next = fetched;
        if (issue_ready) begin
            fetched_next = '0;
        end else if (rd_en) begin
            fetched_next = fetched | grant;
        end

        if (issue_ready) begin
            state_next = opc_pkg::drain;
        end else if (fetched_next != '0) begin
            state_next = opc_pkg::read;
        end else begin
            state_next = opc_pkg::idle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= opc_pkg::idle;
            fetched  <= '0;
            out_full <= 1'b0;
        end else begin
            state    <= state_next;
            fetched  <= fetched_next;
            out_full <= stall;
        end
    end

    // the arbiter may only grant sources that are still pending
    grant_in_pending: assert property (@(posedge clk) disable iff (reset)
        (grant & ~pending) == '0);

    out_valid_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid);

endmodule

`default_nettype wire

// ==== logic/operand_gather.sv ====
// operand gather and output register
`timescale 1ns/1ps
`default_nettype none

module operand_gather (
    input  wire                                              clk,
    input  wire                                              reset,
    input  wire opc_pkg::bank_rd_t [opc_pkg::num_banks-1:0]  bank_rd,
    input  wire                                              rd_en,
    input  wire opc_pkg::lane_vec_t [opc_pkg::num_banks-1:0] rd_data,
    input  wire opc_pkg::issue_req_t                         issue_req,
    input  wire                                              issue_fire,
    input  wire                                              load_out,
    input  wire                                              out_ready,
    output opc_pkg::operands_t                               out_data
);

    logic [opc_pkg::num_banks-1:0]             rd_vld_q;
    opc_pkg::src_idx_t [opc_pkg::num_banks-1:0] rd_src_q;
    opc_pkg::lane_vec_t [opc_pkg::num_srcs-1:0] part_q;
    opc_pkg::lane_vec_t [opc_pkg::num_srcs-1:0] part_m;
    opc_pkg::tag_t                             tag_q;
    opc_pkg::warp_id_t                         warp_q;
    opc_pkg::tmask_t                           tmask_q;
    opc_pkg::reg_num_t                         rd_q;
    opc_pkg::operands_t                        out_m;
    opc_pkg::operands_t                        out_q;

    // routing travels alongside the one-cycle bank read
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_vld_q <= '0;
        end else begin
            for (int b = 0; b < opc_pkg::num_banks; b++) begin
                rd_vld_q[b] <= rd_en && bank_rd[b].valid;
            end
        end
        for (int b = 0; b < opc_pkg::num_banks; b++) begin
            rd_src_q[b] <= bank_rd[b].src;
        end
    end

    always_comb begin
        part_m = part_q;
        for (int b = 0; b < opc_pkg::num_banks; b++) begin
            for (int s = 0; s < opc_pkg::num_srcs; s++) begin
                if (rd_vld_q[b] && (rd_src_q[b] == opc_pkg::src_idx_t'(s))) begin
                    part_m[s] = rd_data[b];
                end
            end
        end
    end

    // partial operands start from zero for each instruction
    always_ff @(posedge clk) begin
        if (reset || load_out) begin
            part_q <= '0;
        end else begin
            part_q <= part_m;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            tag_q   <= issue_req.tag;
            warp_q  <= issue_req.warp;
            tmask_q <= issue_req.tmask;
            rd_q    <= issue_req.rd;
        end
    end

    always_comb begin
        out_m.tag      = tag_q;
        out_m.warp     = warp_q;
        out_m.tmask    = tmask_q;
        out_m.rd       = rd_q;
        out_m.rs1_data = part_m[0];
        out_m.rs2_data = part_m[1];
        out_m.rs3_data = part_m[2];
    end

    // only a result that is not taken right away needs holding
    always_ff @(posedge clk) begin
        if (load_out && !out_ready) begin
            out_q <= out_m;
        end
    end

    assign out_data = load_out ? out_m : out_q;

endmodule

`default_nettype wire

// ==== logic/operand_collector.sv ====
// operand collector top
`timescale 1ns/1ps
`default_nettype none

module operand_collector (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      issue_valid,
    input  wire opc_pkg::issue_req_t issue_req,
    output logic                     issue_ready,
    input  wire                      wb_valid,
    input  wire opc_pkg::wb_req_t    wb_req,
    output logic                     out_valid,
    output opc_pkg::operands_t       out_data,
    input  wire                      out_ready
);

    opc_pkg::src_mask_t                         pending;
    opc_pkg::src_mask_t                         grant;
    opc_pkg::bank_rd_t [opc_pkg::num_banks-1:0]  bank_rd;
    opc_pkg::lane_vec_t [opc_pkg::num_banks-1:0] rd_data;
    logic                                       rd_en;
    logic                                       load_out;

    collect_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .issue_ready (issue_ready),
        .pending     (pending),
        .grant       (grant),
        .rd_en       (rd_en),
        .load_out    (load_out),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    bank_arbiter u_arb (
        .issue_req (issue_req),
        .pending   (pending),
        .bank_rd   (bank_rd),
        .grant     (grant)
    );

    operand_gather u_gather (
        .clk        (clk),
        .reset      (reset),
        .bank_rd    (bank_rd),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .issue_req  (issue_req),
        .issue_fire (issue_valid && issue_ready),
        .load_out   (load_out),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

    // writeback bank comes from the low register bits, entry from warp and the rest
    for (genvar b = 0; b < opc_pkg::num_banks; b++) begin : g_bank
        gpr_bank u_bank (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (wb_valid && (wb_req.rd[opc_pkg::bank_bits-1:0]
                                   == opc_pkg::bank_sel_t'(b))),
            .wr_addr ({wb_req.warp, wb_req.rd[opc_pkg::reg_bits-1:opc_pkg::bank_bits]}),
            .wr_mask (wb_req.tmask),
            .wr_data (wb_req.data),
            .rd_en   (rd_en && bank_rd[b].valid),
            .rd_addr (bank_rd[b].addr),
            .rd_data (rd_data[b])
        );
    end

endmodule

`default_nettype wire

// ==== dv/opc_tests.svh ====
// operand collector directed tests

    task automatic test_reset_zero();
        begin_test();
        #5;
        if (issue_ready || out_valid) report_error("issue_ready or out_valid high after reset");
        @(negedge clk);
        issue_checked(make_req(2, 4'hb, 7, 5, 10, 31, 8'h5a));
        issue_checked(make_req(1, 4'h1, 3, 0, 12, 0, 8'ha5));
        drain();
        end_test("reset_zero");
    endtask

    task automatic test_distinct_banks();
        begin_test();
        write_reg(1, 1, 4'hf, rand_lanes());
        write_reg(1, 2, 4'hf, rand_lanes());
        write_reg(1, 7, 4'hf, rand_lanes());
        // same register in another warp must not leak into warp 1
        write_reg(2, 1, 4'hf, rand_lanes());
        issue_checked(make_req(1, 4'hf, 4, 1, 2, 7, 8'h11));
        drain();
        end_test("distinct_banks");
    endtask

    task automatic test_partial_mask();
        begin_test();
        write_reg(3, 4, 4'hf, rand_lanes());
        write_reg(3, 4, 4'h5, rand_lanes());
        write_reg(3, 8, 4'hf, rand_lanes());
        write_reg(3, 8, 4'h8, rand_lanes());
        write_reg(3, 0, 4'hf, rand_lanes());
        write_reg(3, 12, 4'h0, rand_lanes());
        issue_checked(make_req(3, 4'h6, 9, 4, 0, 8, 8'h33));
        issue_checked(make_req(3, 4'hf, 5, 12, 0, 4, 8'h34));
        drain();
        end_test("partial_mask");
    endtask

    task automatic test_bank_conflicts();
        begin_test();
        write_reg(0, 1, 4'hf, rand_lanes());
        write_reg(0, 5, 4'hf, rand_lanes());
        write_reg(0, 9, 4'hf, rand_lanes());
        write_reg(0, 13, 4'hf, rand_lanes());
        write_reg(0, 2, 4'hf, rand_lanes());
        write_reg(0, 6, 4'hf, rand_lanes());
        issue_checked(make_req(0, 4'hf, 3, 1, 5, 9, 8'h40));
        issue_checked(make_req(0, 4'hf, 3, 5, 5, 2, 8'h41));
        issue_checked(make_req(0, 4'h7, 4, 6, 13, 2, 8'h42));
        issue_checked(make_req(0, 4'hf, 8, 13, 13, 13, 8'h43));
        issue_checked(make_req(0, 4'h9, 1, 0, 9, 1, 8'h44));
        drain();
        end_test("bank_conflicts");
    endtask

    task automatic test_back_pressure();
        begin_test();
        write_reg(0, 3, 4'hf, rand_lanes());
        write_reg(0, 10, 4'hf, rand_lanes());
        out_ready = 1'b0;
        issue_checked(make_req(0, 4'h3, 1, 3, 10, 0, 8'h70));
        start_issue(make_req(0, 4'hc, 2, 10, 3, 3, 8'h71));
        repeat (6) begin
            tick();
            if (fired) report_error("instruction accepted while the output was held");
        end
        out_ready = 1'b1;
        while (!fired) tick();
        issue_valid = 1'b0;
        drain();
        end_test("back_pressure");
    endtask

    task automatic test_random_stream();
        int n_wb;
        begin_test();
        rand_ready = 1'b1;
        for (int i = 0; i < random_iters; i++) begin
            n_wb = int'(next_rand() % 4);
            // a small register range keeps bank conflicts and rewrites frequent
            for (int k = 0; k < n_wb; k++) begin
                write_reg(int'(next_rand() % 4), int'(next_rand() % 8),
                          int'(next_rand() % 16), rand_lanes());
            end
            issue_checked(make_req(int'(next_rand() % 4), int'(next_rand() % 16),
                                   int'(next_rand() % 32), int'(next_rand() % 8),
                                   int'(next_rand() % 8), int'(next_rand() % 8), i));
        end
        drain();
        rand_ready = 1'b0;
        out_ready = 1'b1;
        end_test("random_stream");
    endtask

// ==== dv/opc_tb.sv ====
// operand collector testbench
`timescale 1ns/1ps
`default_nettype none

module opc_tb;

    localparam int random_iters = 40;
    // reset, the five directed tests, the random stream and some slack for stalls
    localparam int cycle_limit = 16 + 8 + 12 + 16 + 24 + 20 + random_iters * 16 + 200;

    logic                clk;
    logic                reset;
    logic                issue_valid;
    opc_pkg::issue_req_t issue_req;
    logic                issue_ready;
    logic                wb_valid;
    opc_pkg::wb_req_t    wb_req;
    logic                out_valid;
    opc_pkg::operands_t  out_data;
    logic                out_ready;

    opc_pkg::lane_vec_t  ref_regs [opc_pkg::num_warps][opc_pkg::num_regs];
    opc_pkg::operands_t  exp_q [$];
    opc_pkg::operands_t  held_data;
    logic [31:0]         rng;
    logic                rand_ready;
    logic                fired;
    logic                fire_prev;
    logic                hold_prev;
    int                  outstanding;
    int                  errors;
    int                  checks;
    int                  test_base;
    int                  tests_run;
    int                  cycle_count;

    operand_collector UUT (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_req      (wb_req),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic opc_pkg::lane_vec_t rand_lanes();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    function automatic opc_pkg::issue_req_t make_req(int warp, int tmask, int rd,
                                                     int rs1, int rs2, int rs3, int tag);
        opc_pkg::issue_req_t r;
        r.warp  = opc_pkg::warp_id_t'(warp);
        r.tmask = opc_pkg::tmask_t'(tmask);
        r.rd    = opc_pkg::reg_num_t'(rd);
        r.rs1   = opc_pkg::reg_num_t'(rs1);
        r.rs2   = opc_pkg::reg_num_t'(rs2);
        r.rs3   = opc_pkg::reg_num_t'(rs3);
        r.tag   = opc_pkg::tag_t'(tag);
        return r;
    endfunction

    // register 0 reads as zero whatever was written to it
    function automatic opc_pkg::lane_vec_t model_read(opc_pkg::warp_id_t w, opc_pkg::reg_num_t r);
        return (r == '0) ? '0 : ref_regs[w][r];
    endfunction

    function automatic opc_pkg::operands_t expected_operands(opc_pkg::issue_req_t req);
        opc_pkg::operands_t e;
        e.tag      = req.tag;
        e.warp     = req.warp;
        e.tmask    = req.tmask;
        e.rd       = req.rd;
        e.rs1_data = model_read(req.warp, req.rs1);
        e.rs2_data = model_read(req.warp, req.rs2);
        e.rs3_data = model_read(req.warp, req.rs3);
        return e;
    endfunction

    // largest count of non-zero sources that share the bank given by their low two bits
    function automatic int expected_reads(opc_pkg::issue_req_t req);
        int per_bank [opc_pkg::num_banks] = '{default: 0};
        opc_pkg::reg_num_t srcs [3];
        int n;
        srcs = '{req.rs1, req.rs2, req.rs3};
        n = 1;
        foreach (srcs[s]) begin
            if (srcs[s] != '0) begin
                per_bank[srcs[s][1:0]]++;
                if (per_bank[srcs[s][1:0]] > n) n = per_bank[srcs[s][1:0]];
            end
        end
        return n;
    endfunction

    task automatic report_error(string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_lanes(string name, opc_pkg::lane_vec_t got, opc_pkg::lane_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_operands(opc_pkg::operands_t got, opc_pkg::operands_t exp);
        checks++;
        if ({got.tag, got.warp, got.tmask, got.rd} !== {exp.tag, exp.warp, exp.tmask, exp.rd}) begin
            errors++;
            $display("FAIL out_data tag/warp/tmask/rd got %h/%h/%h/%h expected %h/%h/%h/%h",
                     got.tag, got.warp, got.tmask, got.rd, exp.tag, exp.warp, exp.tmask, exp.rd);
        end
        check_lanes("out_data.rs1_data", got.rs1_data, exp.rs1_data);
        check_lanes("out_data.rs2_data", got.rs2_data, exp.rs2_data);
        check_lanes("out_data.rs3_data", got.rs3_data, exp.rs3_data);
    endtask

    task automatic check_cycles(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // advance one clock and sample the outputs in the low phase where they are settled
    task automatic tick();
        opc_pkg::operands_t got;
        logic [31:0]        r;
        if (rand_ready) begin
            r = next_rand();
            out_ready = r[7];
        end
        #5;
        got = out_data;
        if (fire_prev && !out_valid) report_error("out_valid did not rise after the handshake");
        if (hold_prev && !out_valid) report_error("out_valid fell while out_ready was low");
        if (hold_prev && out_valid) check_operands(got, held_data);
        if (out_valid && !out_ready && issue_ready) report_error("issue_ready high while held");
        if (out_valid && outstanding == 0) report_error("out_valid high with nothing accepted");
        fired = issue_valid && issue_ready;
        if (out_valid && out_ready && outstanding > 0) begin
            check_operands(got, exp_q.pop_front());
            outstanding--;
        end
        if (fired) outstanding++;
        hold_prev = out_valid && !out_ready;
        held_data = got;
        fire_prev = fired;
        @(negedge clk);
    endtask

    task automatic write_reg(int warp, int rd, int tmask, opc_pkg::lane_vec_t data);
        opc_pkg::wb_req_t w;
        w.warp  = opc_pkg::warp_id_t'(warp);
        w.tmask = opc_pkg::tmask_t'(tmask);
        w.rd    = opc_pkg::reg_num_t'(rd);
        w.data  = data;
        for (int l = 0; l < opc_pkg::num_threads; l++) begin
            if (w.tmask[l]) begin
                ref_regs[w.warp][w.rd][l*opc_pkg::xlen +: opc_pkg::xlen] =
                    data[l*opc_pkg::xlen +: opc_pkg::xlen];
            end
        end
        wb_valid = 1'b1;
        wb_req   = w;
        tick();
        wb_valid = 1'b0;
    endtask

    task automatic start_issue(opc_pkg::issue_req_t req);
        exp_q.push_back(expected_operands(req));
        issue_req   = req;
        issue_valid = 1'b1;
    endtask

    task automatic issue_op(opc_pkg::issue_req_t req, output int cyc);
        start_issue(req);
        cyc = 0;
        fired = 1'b0;
        while (!fired) begin
            tick();
            // a cycle held by back-pressure issues no reads
            if (!hold_prev) cyc++;
        end
        issue_valid = 1'b0;
    endtask

    task automatic issue_checked(opc_pkg::issue_req_t req);
        int cyc;
        issue_op(req, cyc);
        check_cycles("issue_ready cycle", cyc, expected_reads(req));
    endtask

    task automatic drain();
        while (exp_q.size() > 0) tick();
    endtask

    task automatic begin_test();
        test_base = errors;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == test_base) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - test_base);
    endtask

    `include "opc_tests.svh"

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_req   = '0;
        wb_valid    = 1'b0;
        wb_req      = '0;
        out_ready   = 1'b1;
        rng         = 32'd72674;
        rand_ready  = 1'b0;
        fired       = 1'b0;
        fire_prev   = 1'b0;
        hold_prev   = 1'b0;
        outstanding = 0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        cycle_count = 0;
        foreach (ref_regs[w, r]) ref_regs[w][r] = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        test_reset_zero();
        test_distinct_banks();
        test_partial_mask();
        test_bank_conflicts();
        test_back_pressure();
        test_random_stream();
        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+dv
logic/opc_pkg.sv
logic/gpr_bank.sv
logic/bank_arbiter.sv
logic/collect_ctrl.sv
logic/operand_gather.sv
logic/operand_collector.sv
dv/opc_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := opc_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
